//--- mipsSettings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// datapath and address width
`define MIPS_XLEN 32

// register file geometry
`define MIPS_REG_AW 5
`define MIPS_NUM_REGS 32

// first fetch after reset, boot ROM base
`define MIPS_RESET_PC 32'hbfc00000

`endif

//--- mipsPkg.sv
`include "mipsSettings.svh"

package mipsPkg;

    typedef logic [`MIPS_XLEN-1:0] wordT;
    typedef logic [`MIPS_REG_AW-1:0] regAddrT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // zero so an all-zero ctrl is harmless
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } aluOpT;

    // all zero means nop
    typedef struct packed {
        aluOpT aluOp;
        logic  immSel;    // operand b from imm
        logic  signExt;
        logic  dstRt;     // I-type destination
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        logic  branchNe;
        logic  jump;
    } ctrlT;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        wordT    pc;
        ctrlT    ctrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT dst;
        wordT    rsValue;
        wordT    rtValue;
        wordT    imm;      // already extended
    } idExT;

    typedef struct packed {
        wordT    pc;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        regAddrT dst;
        wordT    aluOut;
        wordT    storeData;
    } exMemT;

endpackage

//--- decoder.sv
module decoder (
    input  mipsPkg::wordT instr_i,
    output mipsPkg::ctrlT ctrl_o
);
    import mipsPkg::*;

    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpJ       = 6'h02;
    localparam logic [5:0] OpBeq     = 6'h04;
    localparam logic [5:0] OpBne     = 6'h05;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpLui     = 6'h0f;
    localparam logic [5:0] OpLw      = 6'h23;
    localparam logic [5:0] OpSw      = 6'h2b;

    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnXor  = 6'h26;
    localparam logic [5:0] FnSlt  = 6'h2a;

    logic [5:0] opcode;
    logic [5:0] funct;
    ctrlT dec;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        dec = '0;
        case (opcode)
            OpSpecial: begin
                dec.regWrite = 1'b1;
                case (funct)
                    FnAddu:  dec.aluOp = ALU_ADD;
                    FnSubu:  dec.aluOp = ALU_SUB;
                    FnAnd:   dec.aluOp = ALU_AND;
                    FnOr:    dec.aluOp = ALU_OR;
                    FnXor:   dec.aluOp = ALU_XOR;
                    FnSlt:   dec.aluOp = ALU_SLT;
                    default: dec.regWrite = 1'b0; // sll $0 and friends
                endcase
            end
            OpAddiu: dec = '{aluOp: ALU_ADD, immSel: 1'b1, signExt: 1'b1, dstRt: 1'b1,
                             regWrite: 1'b1, default: 1'b0};
            OpOri:   dec = '{aluOp: ALU_OR, immSel: 1'b1, dstRt: 1'b1, regWrite: 1'b1,
                             default: 1'b0};
            OpLui:   dec = '{aluOp: ALU_LUI, immSel: 1'b1, dstRt: 1'b1, regWrite: 1'b1,
                             default: 1'b0};
            OpLw:    dec = '{aluOp: ALU_ADD, immSel: 1'b1, signExt: 1'b1, dstRt: 1'b1,
                             regWrite: 1'b1, memRead: 1'b1, default: 1'b0};
            OpSw:    dec = '{aluOp: ALU_ADD, immSel: 1'b1, signExt: 1'b1, memWrite: 1'b1,
                             default: 1'b0};
            OpBeq:   dec = '{aluOp: ALU_ADD, signExt: 1'b1, branch: 1'b1, default: 1'b0};
            OpBne:   dec = '{aluOp: ALU_ADD, signExt: 1'b1, branch: 1'b1, branchNe: 1'b1,
                             default: 1'b0};
            OpJ:     dec.jump = 1'b1;
            default: dec = '0;
        endcase
        // writes to $0 vanish here
        if ((dec.dstRt ? instr_i[20:16] : instr_i[15:11]) == '0) begin
            dec.regWrite = 1'b0;
        end
    end

    assign ctrl_o = dec;

endmodule

//--- regFile.sv
`include "mipsSettings.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN_i,
    input  logic             we_i,
    input  mipsPkg::regAddrT wa_i,
    input  mipsPkg::wordT    wd_i,
    input  mipsPkg::regAddrT ra1_i,
    input  mipsPkg::regAddrT ra2_i,
    output mipsPkg::wordT    rd1_o,
    output mipsPkg::wordT    rd2_o
);
    import mipsPkg::*;

    wordT regs [1:`MIPS_NUM_REGS-1]; // $0 is not stored

    always_ff @(posedge clk) begin
        if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // write-through so D sees the value M writes this cycle
    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && ra1_i == wa_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && ra2_i == wa_i) ? wd_i : regs[ra2_i];

    // decoder is expected to have dropped these
    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN_i) we_i |-> wa_i != '0)
        else $error("register file write to $0");

endmodule

//--- stageReg.sv
module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    hold_i,
    input  logic    clear_i,
    input  payloadT d_i,
    output payloadT q_o
);

    // zero payload is a bubble
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            if (clear_i) begin
                q_o <= '0;
            end else begin
                q_o <= d_i;
            end
        end
    end

endmodule

//--- alu.sv
module alu (
    input  mipsPkg::aluOpT op_i,
    input  mipsPkg::wordT  a_i,
    input  mipsPkg::wordT  b_i,
    output mipsPkg::wordT  y_o
);
    import mipsPkg::*;

    logic lessThan;

    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i; // wraps, no overflow trap
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            ALU_SLT: y_o = {{($bits(wordT) - 1){1'b0}}, lessThan};
            ALU_LUI: y_o = b_i << 16;
            default: y_o = '0;
        endcase
    end

endmodule

//--- hazardUnit.sv
module hazardUnit (
    input  mipsPkg::regAddrT rsD_i,
    input  mipsPkg::regAddrT rtD_i,
    input  mipsPkg::regAddrT rsE_i,
    input  mipsPkg::regAddrT rtE_i,
    input  mipsPkg::regAddrT dstE_i,
    input  mipsPkg::regAddrT dstM_i,
    input  logic             regWriteM_i,
    input  logic             memReadE_i,
    input  logic             takenE_i,
    input  logic             iStall_i,
    input  logic             dStall_i,
    output logic             freeze_o,
    output logic             stallD_o,
    output logic             flushD_o,
    output logic             flushE_o,
    output logic             fwdA_o,
    output logic             fwdB_o
);
    logic loadUse;

    assign freeze_o = iStall_i | dStall_i; // either port busy stops everything

    // load in E feeding D, one bubble then write-through covers it
    assign loadUse = memReadE_i && dstE_i != '0 && (dstE_i == rsD_i || dstE_i == rtD_i);

    assign stallD_o = loadUse;
    assign flushE_o = loadUse;
    assign flushD_o = takenE_i; // drop the fetch after the delay slot

    // regWrite already implies dst != $0
    assign fwdA_o = regWriteM_i && dstM_i == rsE_i;
    assign fwdB_o = regWriteM_i && dstM_i == rtE_i;

    // E holds either a load or a branch, never both
    always_comb begin
        if (!freeze_o) begin
            assert (!(flushD_o && stallD_o))
                else $error("branch flush and load-use stall together");
        end
    end

endmodule

//--- datapath.sv
`include "mipsSettings.svh"

module datapath (
    input  logic             clk,
    input  logic             rstN_i,
    input  logic             iStall_i,
    input  logic             dStall_i,
    output mipsPkg::wordT    pcF_o,
    output logic             instEnF_o,
    input  mipsPkg::wordT    instrF_i,
    output logic             memEnM_o,
    output mipsPkg::wordT    memAddrM_o,
    output logic [3:0]       memWenM_o,
    output mipsPkg::wordT    memWdataM_o,
    input  mipsPkg::wordT    memRdataM_i,
    output mipsPkg::wordT    debugWbPc_o,
    output logic [3:0]       debugWbRfWen_o,
    output mipsPkg::regAddrT debugWbRfWnum_o,
    output mipsPkg::wordT    debugWbRfWdata_o
);
    import mipsPkg::*;

    logic freeze;
    logic stallD;
    logic flushD;
    logic flushE;
    logic fwdA;
    logic fwdB;
    logic takenE;
    logic rfWenM;
    wordT pcF;
    wordT pcNext;
    wordT pcPlus4F;
    wordT pcPlus4D;
    wordT jumpTargetD;
    wordT immD;
    wordT rd1D;
    wordT rd2D;
    wordT rsValE;
    wordT rtValE;
    wordT aluBE;
    wordT aluOutE;
    wordT branchTargetE;
    wordT resultM;
    regAddrT rsD;
    regAddrT rtD;
    regAddrT dstD;
    ctrlT ctrlD;
    ifIdT ifIdF;
    ifIdT ifIdD;
    idExT idExD;
    idExT idExE;
    exMemT exMemE;
    exMemT exMemM;

    hazardUnit hazard (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(idExE.rs), .rtE_i(idExE.rt),
        .dstE_i(idExE.dst), .dstM_i(exMemM.dst), .regWriteM_i(exMemM.regWrite),
        .memReadE_i(idExE.ctrl.memRead), .takenE_i(takenE),
        .iStall_i(iStall_i), .dStall_i(dStall_i),
        .freeze_o(freeze), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

    // F
    assign pcPlus4F = pcF + 32'd4;
    // a taken branch in E outranks J in D, which would be its delay slot
    assign pcNext = takenE ? branchTargetE : ctrlD.jump ? jumpTargetD : pcPlus4F;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcF <= `MIPS_RESET_PC;
        end else if (!(freeze || stallD)) begin
            pcF <= pcNext;
        end
    end

    assign pcF_o     = pcF;
    assign instEnF_o = ~flushD; // fetch is thrown away on a taken branch
    assign ifIdF     = '{pc: pcF, instr: instrF_i};

    stageReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .rstN_i(rstN_i), .hold_i(freeze || stallD), .clear_i(flushD),
        .d_i(ifIdF), .q_o(ifIdD)
    );

    // D
    decoder decoderD (.instr_i(ifIdD.instr), .ctrl_o(ctrlD));

    assign rsD  = ifIdD.instr[25:21];
    assign rtD  = ifIdD.instr[20:16];
    assign dstD = ctrlD.dstRt ? rtD : ifIdD.instr[15:11];
    assign immD = ctrlD.signExt ? {{16{ifIdD.instr[15]}}, ifIdD.instr[15:0]}
                                : {16'b0, ifIdD.instr[15:0]};
    assign pcPlus4D    = ifIdD.pc + 32'd4;
    assign jumpTargetD = {pcPlus4D[31:28], ifIdD.instr[25:0], 2'b00};

    regFile regFileD (
        .clk(clk), .rstN_i(rstN_i), .we_i(rfWenM), .wa_i(exMemM.dst), .wd_i(resultM),
        .ra1_i(rsD), .ra2_i(rtD), .rd1_o(rd1D), .rd2_o(rd2D)
    );

    assign idExD = '{pc: ifIdD.pc, ctrl: ctrlD, rs: rsD, rt: rtD, dst: dstD,
                     rsValue: rd1D, rtValue: rd2D, imm: immD};

    stageReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rstN_i(rstN_i), .hold_i(freeze), .clear_i(flushE),
        .d_i(idExD), .q_o(idExE)
    );

    // E
    assign rsValE = fwdA ? exMemM.aluOut : idExE.rsValue;
    assign rtValE = fwdB ? exMemM.aluOut : idExE.rtValue;
    assign aluBE  = idExE.ctrl.immSel ? idExE.imm : rtValE;

    alu aluE (.op_i(idExE.ctrl.aluOp), .a_i(rsValE), .b_i(aluBE), .y_o(aluOutE));

    assign takenE = idExE.ctrl.branch && ((rsValE == rtValE) != idExE.ctrl.branchNe);
    assign branchTargetE = idExE.pc + 32'd4 + {idExE.imm[29:0], 2'b00};

    assign exMemE = '{pc: idExE.pc, regWrite: idExE.ctrl.regWrite,
                      memRead: idExE.ctrl.memRead, memWrite: idExE.ctrl.memWrite,
                      dst: idExE.dst, aluOut: aluOutE, storeData: rtValE};

    stageReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rstN_i(rstN_i), .hold_i(freeze), .clear_i(1'b0),
        .d_i(exMemE), .q_o(exMemM)
    );

    // M stage writes the register file
    assign memEnM_o    = exMemM.memRead | exMemM.memWrite;
    assign memAddrM_o  = exMemM.aluOut;
    assign memWenM_o   = {4{exMemM.memWrite & ~freeze}}; // word stores only
    assign memWdataM_o = exMemM.storeData;
    assign resultM     = exMemM.memRead ? memRdataM_i : exMemM.aluOut;
    assign rfWenM      = exMemM.regWrite & ~freeze;

    assign debugWbPc_o      = exMemM.pc;
    assign debugWbRfWen_o   = {4{rfWenM}};
    assign debugWbRfWnum_o  = exMemM.dst;
    assign debugWbRfWdata_o = resultM;

    // a frozen core keeps every stage record in place
    frozenHolds: assert property (@(posedge clk) disable iff (!rstN_i)
        freeze |=> $stable(ifIdD) && $stable(idExE) && $stable(exMemM))
        else $error("stage record changed while frozen");

endmodule

//--- tbDatapath.sv
`include "mipsSettings.svh"

module tbDatapath;
    timeunit 1ns;
    timeprecision 1ps;

    import mipsPkg::*;

    localparam int MaxCycles = 3000; // well above the length of all runs together

    logic       clk;
    logic       rstN_i;
    logic       iStall_i;
    logic       dStall_i;
    wordT       pcF_o;
    logic       instEnF_o;
    wordT       instrF_i;
    logic       memEnM_o;
    wordT       memAddrM_o;
    logic [3:0] memWenM_o;
    wordT       memWdataM_o;
    wordT       memRdataM_i;
    wordT       debugWbPc_o;
    logic [3:0] debugWbRfWen_o;
    regAddrT    debugWbRfWnum_o;
    wordT       debugWbRfWdata_o;

    wordT    imem [0:255];
    wordT    dmem [0:255];
    wordT    wbPcQ [$];
    regAddrT wbRegQ [$];
    wordT    wbDataQ [$];
    wordT    storeAddrQ [$];
    wordT    storeDataQ [$];
    logic    stallsOn;
    int      cycles;
    int      frozenCycles;

    datapath u_datapath (.*);

    assign instrF_i    = imem[pcF_o[9:2]];
    assign memRdataM_i = dmem[memAddrM_o[9:2]];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (memEnM_o && memWenM_o != '0) begin
            dmem[memAddrM_o[9:2]] <= memWdataM_o;
        end
    end

    // random back-pressure on both ports
    always @(posedge clk) begin
        if (stallsOn) begin
            iStall_i <= ($urandom % 32'd3) == 32'd0;
            dStall_i <= ($urandom % 32'd4) == 32'd0;
        end else begin
            iStall_i <= 1'b0;
            dStall_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("timeout: tests still running after %0d cycles", MaxCycles);
            stopWithFailure();
        end
    end

    task automatic stopWithFailure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkRegAddr(string name, regAddrT got, regAddrT exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkWen(string name, logic [3:0] got, logic [3:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            stopWithFailure();
        end
    endtask

    function automatic wordT rInstr(regAddrT rs, regAddrT rt, regAddrT rd, logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic wordT iInstr(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jInstr(wordT target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic wordT pcAt(int idx);
        return `MIPS_RESET_PC + (32'(idx) << 2);
    endfunction

    function automatic wordT fillWord(logic [7:0] a);
        return {~a, a, a ^ 8'h5a, a + 8'h3c}; // distinct for every word address
    endfunction

    task automatic clearMemories();
        int i;
        for (i = 0; i < 256; i++) begin
            imem[i[7:0]] = 32'h0000_0000; // sll $0 acts as nop
            dmem[i[7:0]] <= fillWord(i[7:0]);
        end
    endtask

    task automatic putInstr(int idx, wordT instr);
        imem[idx[7:0]] = instr;
    endtask

    task automatic expectWb(int idx, regAddrT rd, wordT value);
        wbPcQ.push_back(pcAt(idx));
        wbRegQ.push_back(rd);
        wbDataQ.push_back(value);
    endtask

    task automatic expectStore(wordT addr, wordT data);
        storeAddrQ.push_back(addr);
        storeDataQ.push_back(data);
    endtask

    task automatic enterReset();
        @(posedge clk);
        rstN_i <= 1'b0;
        clearMemories();
    endtask

    task automatic leaveReset();
        repeat (10) @(posedge clk);
        rstN_i <= 1'b1;
    endtask

    // runs until every expected event is seen plus a few idle cycles for strays
    task automatic runAndCheck(logic withStalls);
        int idle;
        idle = 0;
        frozenCycles = 0;
        stallsOn <= withStalls;
        while (idle < 12) begin
            @(negedge clk);
            if (iStall_i || dStall_i) begin
                frozenCycles++;
                checkWen("debugWbRfWen_o", debugWbRfWen_o, 4'h0);
                checkWen("memWenM_o", memWenM_o, 4'h0);
            end
            if (memWenM_o != '0) begin
                if (storeAddrQ.size() == 0) begin
                    $display("store seen on the data port where none was expected");
                    stopWithFailure();
                end
                checkWen("memWenM_o", memWenM_o, 4'hf);
                checkBit("memEnM_o", memEnM_o, 1'b1);
                checkWord("memAddrM_o", memAddrM_o, storeAddrQ.pop_front());
                checkWord("memWdataM_o", memWdataM_o, storeDataQ.pop_front());
            end
            if (debugWbRfWen_o != '0) begin
                if (wbPcQ.size() == 0) begin
                    $display("register write-back seen after all expected ones");
                    stopWithFailure();
                end
                checkWen("debugWbRfWen_o", debugWbRfWen_o, 4'hf);
                checkWord("debugWbPc_o", debugWbPc_o, wbPcQ.pop_front());
                checkRegAddr("debugWbRfWnum_o", debugWbRfWnum_o, wbRegQ.pop_front());
                checkWord("debugWbRfWdata_o", debugWbRfWdata_o, wbDataQ.pop_front());
            end
            if (wbPcQ.size() == 0 && storeAddrQ.size() == 0) begin
                idle++;
            end
        end
        stallsOn <= 1'b0;
        if (withStalls && frozenCycles == 0) begin
            $display("random stalls never froze the core during the run");
            stopWithFailure();
        end
    endtask

    task automatic testReset();
        enterReset();
        leaveReset();
        @(negedge clk);
        checkWord("pcF_o", pcF_o, `MIPS_RESET_PC);
        checkBit("instEnF_o", instEnF_o, 1'b1);
        checkBit("memEnM_o", memEnM_o, 1'b0);
        checkWen("memWenM_o", memWenM_o, 4'h0);
        checkWen("debugWbRfWen_o", debugWbRfWen_o, 4'h0);
    endtask

    task automatic testArithmetic(logic withStalls);
        enterReset();
        putInstr(0, iInstr(6'h09, 5'd0, 5'd1, 16'h0005));  // addiu $1, $0, 5
        putInstr(1, iInstr(6'h0f, 5'd0, 5'd2, 16'h1234));  // lui
        putInstr(2, iInstr(6'h0d, 5'd2, 5'd2, 16'h8765));  // ori zero-extends
        putInstr(3, rInstr(5'd2, 5'd1, 5'd3, 6'h21));      // addu
        putInstr(4, rInstr(5'd3, 5'd1, 5'd4, 6'h23));      // subu
        putInstr(5, rInstr(5'd4, 5'd3, 5'd5, 6'h24));      // and
        putInstr(6, rInstr(5'd5, 5'd1, 5'd6, 6'h25));      // or
        putInstr(7, rInstr(5'd6, 5'd3, 5'd7, 6'h26));      // xor
        putInstr(8, iInstr(6'h09, 5'd7, 5'd0, 16'h0007));  // to $0 so no write-back
        putInstr(9, iInstr(6'h09, 5'd0, 5'd9, 16'hfffe));  // -2
        putInstr(10, rInstr(5'd9, 5'd7, 5'd8, 6'h2a));     // slt with signed -2 < 15
        expectWb(0, 5'd1, 32'h0000_0005);
        expectWb(1, 5'd2, 32'h1234_0000);
        expectWb(2, 5'd2, 32'h1234_8765);
        expectWb(3, 5'd3, 32'h1234_876a);
        expectWb(4, 5'd4, 32'h1234_8765);
        expectWb(5, 5'd5, 32'h1234_8760);
        expectWb(6, 5'd6, 32'h1234_8765);
        expectWb(7, 5'd7, 32'h0000_000f);
        expectWb(9, 5'd9, 32'hffff_fffe);
        expectWb(10, 5'd8, 32'h0000_0001);
        leaveReset();
        runAndCheck(withStalls);
    endtask

    task automatic testMemory(logic withStalls);
        enterReset();
        putInstr(0, iInstr(6'h09, 5'd0, 5'd10, 16'h0040)); // base address
        putInstr(1, iInstr(6'h0f, 5'd0, 5'd11, 16'hcafe));
        putInstr(2, iInstr(6'h0d, 5'd11, 5'd11, 16'hf00d));
        putInstr(3, iInstr(6'h2b, 5'd10, 5'd11, 16'h0008)); // sw $11, 8($10)
        putInstr(4, iInstr(6'h23, 5'd10, 5'd12, 16'h0008)); // lw $12, 8($10)
        putInstr(5, rInstr(5'd12, 5'd11, 5'd13, 6'h21));    // load-use
        putInstr(6, iInstr(6'h23, 5'd10, 5'd14, 16'h0004)); // untouched word
        expectWb(0, 5'd10, 32'h0000_0040);
        expectWb(1, 5'd11, 32'hcafe_0000);
        expectWb(2, 5'd11, 32'hcafe_f00d);
        expectStore(32'h0000_0048, 32'hcafe_f00d);
        expectWb(4, 5'd12, 32'hcafe_f00d);
        expectWb(5, 5'd13, 32'h95fd_e01a);
        expectWb(6, 5'd14, fillWord(8'd17));
        leaveReset();
        runAndCheck(withStalls);
        checkWord("dmem[18]", dmem[18], 32'hcafe_f00d);
    endtask

    task automatic testControlFlow();
        enterReset();
        putInstr(0, iInstr(6'h09, 5'd0, 5'd1, 16'h0001));
        putInstr(1, iInstr(6'h09, 5'd0, 5'd2, 16'h0001));
        putInstr(2, iInstr(6'h04, 5'd1, 5'd2, 16'h0003));  // beq taken to 6
        putInstr(3, iInstr(6'h09, 5'd0, 5'd3, 16'h0003));  // delay slot
        putInstr(4, iInstr(6'h09, 5'd0, 5'd4, 16'h0004));  // flushed
        putInstr(5, iInstr(6'h09, 5'd0, 5'd4, 16'h0005));
        putInstr(6, iInstr(6'h05, 5'd1, 5'd2, 16'h0005));  // bne not taken
        putInstr(7, iInstr(6'h09, 5'd0, 5'd5, 16'h0007));
        putInstr(8, iInstr(6'h09, 5'd0, 5'd6, 16'h0008));
        putInstr(9, jInstr(pcAt(20)));
        putInstr(10, iInstr(6'h09, 5'd0, 5'd7, 16'h000a)); // j delay slot
        putInstr(11, iInstr(6'h09, 5'd0, 5'd8, 16'h000b)); // never fetched
        putInstr(20, iInstr(6'h09, 5'd0, 5'd8, 16'h0014));
        expectWb(0, 5'd1, 32'd1);
        expectWb(1, 5'd2, 32'd1);
        expectWb(3, 5'd3, 32'd3);
        expectWb(7, 5'd5, 32'd7);
        expectWb(8, 5'd6, 32'd8);
        expectWb(10, 5'd7, 32'd10);
        expectWb(20, 5'd8, 32'd20);
        leaveReset();
        runAndCheck(1'b0);
    endtask

    initial begin
        clk = 1'b0;
        rstN_i <= 1'b0;
        iStall_i <= 1'b0;
        dStall_i <= 1'b0;
        stallsOn <= 1'b0;
        cycles <= 0;
        void'($urandom(32'hc708886f));
        clearMemories();
        testReset();
        testArithmetic(1'b0);
        testMemory(1'b0);
        testControlFlow();
        testArithmetic(1'b1);
        testMemory(1'b1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
mipsPkg.sv
decoder.sv
regFile.sv
stageReg.sv
alu.sv
hazardUnit.sv
datapath.sv
tbDatapath.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tbDatapath -o simDatapath

./obj_dir/simDatapath
